// File: ce_pkg.sv
// ------------------------------------------------
// Shared definitions for the FP16 computing element
// FP16 field widths, pipeline depth, stage-1
// operation codes and the FP16 word union.
// Modules refer to these by scoped names.
// ------------------------------------------------

package ce_pkg;

  // FP16 format
  localparam int unsigned FP_WIDTH  = 16;
  localparam int unsigned EXP_WIDTH = 5;
  localparam int unsigned MAN_WIDTH = 10;
  localparam int unsigned EXP_BIAS  = 15;

  // Register stages from operands to Z
  localparam int unsigned PIPE_DEPTH = 2;

  // Stage-1 operation codes, the unused fourth code behaves as OP1_MINMAX
  localparam int unsigned OP_WIDTH = 2;

  localparam logic [OP_WIDTH-1:0] OP1_MUL     = 2'd0;
  localparam logic [OP_WIDTH-1:0] OP1_MUL_CMP = 2'd1;
  localparam logic [OP_WIDTH-1:0] OP1_MINMAX  = 2'd2;

  // Canonical quiet NaN
  localparam logic [FP_WIDTH-1:0] FP_QNAN = 16'h7E00;

  // One FP16 word, seen as raw bits or as its fields
  typedef union packed {
    logic [FP_WIDTH-1:0] raw;
    struct packed {
      logic                 sign;
      logic [EXP_WIDTH-1:0] exponent;
      logic [MAN_WIDTH-1:0] mantissa;
    } fld;
  } fp16_u;

endpackage

// File: ce_fp_mul.sv
// ------------------------------------------------
// Pipelined FP16 multiplier
// Rounds toward zero and flushes subnormal inputs
// and results to zero. The product leaves after
// PIPE_DEPTH enabled clock edges.
// ------------------------------------------------

`timescale 1ns/1ps

module ce_fp_mul (
  input  logic                         stage2_noncomp_input_pipe_clk,
  input  logic                         rst_ni,
  input  logic                         reg_enable_i,
  input  logic [ce_pkg::FP_WIDTH-1:0]  a_i,
  input  logic [ce_pkg::FP_WIDTH-1:0]  b_i,
  output logic [ce_pkg::FP_WIDTH-1:0]  prod_o
);

  ce_pkg::fp16_u a_u;
  ce_pkg::fp16_u b_u;
  ce_pkg::fp16_u res_u;

  logic a_zero;
  logic b_zero;
  logic a_inf;
  logic b_inf;
  logic a_nan;
  logic b_nan;
  logic res_sign;
  logic norm_shift;

  logic [2*ce_pkg::MAN_WIDTH+1:0] sig_prod;
  logic [ce_pkg::MAN_WIDTH-1:0]   man_res;
  logic [ce_pkg::EXP_WIDTH+1:0]   exp_sum;
  logic [ce_pkg::EXP_WIDTH+1:0]   exp_unb;

  logic [ce_pkg::PIPE_DEPTH-1:0][ce_pkg::FP_WIDTH-1:0] pipe_q;

  assign a_u.raw = a_i;
  assign b_u.raw = b_i;

  // Operand classes, subnormals count as zero
  assign a_zero = (a_u.fld.exponent == '0);
  assign b_zero = (b_u.fld.exponent == '0);
  assign a_inf  = (a_u.fld.exponent == '1) && (a_u.fld.mantissa == '0);
  assign b_inf  = (b_u.fld.exponent == '1) && (b_u.fld.mantissa == '0);
  assign a_nan  = (a_u.fld.exponent == '1) && (a_u.fld.mantissa != '0);
  assign b_nan  = (b_u.fld.exponent == '1) && (b_u.fld.mantissa != '0);

  assign res_sign = a_u.fld.sign ^ b_u.fld.sign;

  // 11x11 significand product, at most one place of normalization
  assign sig_prod   = {1'b1, a_u.fld.mantissa} * {1'b1, b_u.fld.mantissa};
  assign norm_shift = sig_prod[2*ce_pkg::MAN_WIDTH+1];
  assign man_res    = norm_shift ? sig_prod[2*ce_pkg::MAN_WIDTH:ce_pkg::MAN_WIDTH+1]
                                 : sig_prod[2*ce_pkg::MAN_WIDTH-1:ce_pkg::MAN_WIDTH];

  // Biased exponent sum still holds one extra bias
  assign exp_sum = (ce_pkg::EXP_WIDTH+2)'(a_u.fld.exponent)
                 + (ce_pkg::EXP_WIDTH+2)'(b_u.fld.exponent)
                 + (ce_pkg::EXP_WIDTH+2)'(norm_shift);
  assign exp_unb = exp_sum - (ce_pkg::EXP_WIDTH+2)'(ce_pkg::EXP_BIAS);

  always_comb begin
    res_u.raw = ce_pkg::FP_QNAN;
    if (a_nan || b_nan || (a_inf && b_zero) || (b_inf && a_zero)) begin
      res_u.raw = ce_pkg::FP_QNAN;
    end else if (a_inf || b_inf || (exp_sum >= ce_pkg::EXP_BIAS + 2**ce_pkg::EXP_WIDTH - 1)) begin
      // Infinity operand or exponent overflow
      res_u.fld.sign     = res_sign;
      res_u.fld.exponent = '1;
      res_u.fld.mantissa = '0;
    end else if (a_zero || b_zero || (exp_sum <= ce_pkg::EXP_BIAS)) begin
      // Zero operand or underflow, flushed
      res_u.fld.sign     = res_sign;
      res_u.fld.exponent = '0;
      res_u.fld.mantissa = '0;
    end else begin
      res_u.fld.sign     = res_sign;
      res_u.fld.exponent = exp_unb[ce_pkg::EXP_WIDTH-1:0];
      res_u.fld.mantissa = man_res;
    end
  end

  always_ff @(posedge stage2_noncomp_input_pipe_clk or negedge rst_ni) begin
    if (!rst_ni) begin
      pipe_q <= '0;
    end else if (reg_enable_i) begin
      pipe_q[0] <= res_u.raw;
      for (int i = 1; i < ce_pkg::PIPE_DEPTH; i++) begin
        pipe_q[i] <= pipe_q[i-1];
      end
    end
  end

  assign prod_o = pipe_q[ce_pkg::PIPE_DEPTH-1];

endmodule

// File: ce_fp_minmax.sv
// ------------------------------------------------
// FP16 minimum / maximum
// max_i high selects the maximum. The result goes
// through NUM_PIPE enabled registers, or straight
// out when NUM_PIPE is 0.
// ------------------------------------------------

`timescale 1ns/1ps

module ce_fp_minmax #(
  parameter int unsigned NUM_PIPE = 0
) (
  input  logic                         stage2_noncomp_input_pipe_clk,
  input  logic                         rst_ni,
  input  logic                         reg_enable_i,
  input  logic [ce_pkg::FP_WIDTH-1:0]  a_i,
  input  logic [ce_pkg::FP_WIDTH-1:0]  b_i,
  input  logic                         max_i,
  output logic [ce_pkg::FP_WIDTH-1:0]  res_o
);

  ce_pkg::fp16_u a_u;
  ce_pkg::fp16_u b_u;

  logic [ce_pkg::FP_WIDTH-1:0] res;
  logic                        a_nan;
  logic                        b_nan;
  logic                        a_lt_b;

  assign a_u.raw = a_i;
  assign b_u.raw = b_i;

  assign a_nan = (a_u.fld.exponent == '1) && (a_u.fld.mantissa != '0);
  assign b_nan = (b_u.fld.exponent == '1) && (b_u.fld.mantissa != '0);

  // Sign first, so -0 sorts below +0; then magnitude, reversed for negatives
  always_comb begin
    if (a_u.fld.sign != b_u.fld.sign) begin
      a_lt_b = a_u.fld.sign;
    end else if (a_u.fld.sign) begin
      a_lt_b = a_u.raw[ce_pkg::FP_WIDTH-2:0] > b_u.raw[ce_pkg::FP_WIDTH-2:0];
    end else begin
      a_lt_b = a_u.raw[ce_pkg::FP_WIDTH-2:0] < b_u.raw[ce_pkg::FP_WIDTH-2:0];
    end
  end

  always_comb begin
    if (a_nan && b_nan) begin
      res = ce_pkg::FP_QNAN;
    end else if (a_nan) begin
      res = b_u.raw;
    end else if (b_nan) begin
      res = a_u.raw;
    end else begin
      res = (a_lt_b ^ max_i) ? a_u.raw : b_u.raw;
    end
  end

  if (NUM_PIPE == 0) begin : gen_comb
    assign res_o = res;
  end else begin : gen_pipe
    logic [NUM_PIPE-1:0][ce_pkg::FP_WIDTH-1:0] pipe_q;

    always_ff @(posedge stage2_noncomp_input_pipe_clk or negedge rst_ni) begin
      if (!rst_ni) begin
        pipe_q <= '0;
      end else if (reg_enable_i) begin
        pipe_q[0] <= res;
        for (int i = 1; i < NUM_PIPE; i++) begin
          pipe_q[i] <= pipe_q[i-1];
        end
      end
    end

    assign res_o = pipe_q[NUM_PIPE-1];
  end

endmodule

// File: ce_result_stage.sv
// ------------------------------------------------
// Output stage of the computing element
// Delays the bias to line up with the stage-1
// result, then either compares the two or passes
// the stage-1 result straight to Z.
// ------------------------------------------------

`timescale 1ns/1ps

module ce_result_stage (
  input  logic                         stage2_noncomp_input_pipe_clk,
  input  logic                         rst_ni,
  input  logic                         reg_enable_i,
  input  logic [ce_pkg::FP_WIDTH-1:0]  y_i,
  input  logic [ce_pkg::FP_WIDTH-1:0]  mul_res_i,
  input  logic [ce_pkg::FP_WIDTH-1:0]  minmax_res_i,
  input  logic                         sel_minmax_i,
  input  logic                         cmp_en_i,
  input  logic                         cmp_max_i,
  output logic [ce_pkg::FP_WIDTH-1:0]  z_o
);

  logic [ce_pkg::PIPE_DEPTH-1:0][ce_pkg::FP_WIDTH-1:0] y_q;
  logic [ce_pkg::FP_WIDTH-1:0]                         stage1_res;
  logic [ce_pkg::FP_WIDTH-1:0]                         cmp_res;

  // Bias delay line, moves with the data pipeline
  always_ff @(posedge stage2_noncomp_input_pipe_clk or negedge rst_ni) begin
    if (!rst_ni) begin
      y_q <= '0;
    end else if (reg_enable_i) begin
      y_q[0] <= y_i;
      for (int i = 1; i < ce_pkg::PIPE_DEPTH; i++) begin
        y_q[i] <= y_q[i-1];
      end
    end
  end

  assign stage1_res = sel_minmax_i ? minmax_res_i : mul_res_i;

  // Stage-2 comparison against the aligned bias
  ce_fp_minmax #(
    .NUM_PIPE (0)
  ) i_stage2_minmax (
    .stage2_noncomp_input_pipe_clk (stage2_noncomp_input_pipe_clk),
    .rst_ni                        (rst_ni),
    .reg_enable_i                  (reg_enable_i),
    .a_i                           (stage1_res),
    .b_i                           (y_q[ce_pkg::PIPE_DEPTH-1]),
    .max_i                         (cmp_max_i),
    .res_o                         (cmp_res)
  );

  assign z_o = cmp_en_i ? cmp_res : stage1_res;

endmodule

// File: ce_ctrl.sv
// ------------------------------------------------
// Control pipeline of the computing element
// Carries valid bit, operation code and stage-2
// min/max selector of each item alongside the data
// and decodes the last stage to steer the output.
// ------------------------------------------------

`timescale 1ns/1ps

module ce_ctrl (
  input  logic                           stage2_noncomp_input_pipe_clk,
  input  logic                           rst_ni,
  input  logic                           in_valid_i,
  input  logic                           reg_enable_i,
  input  logic                           flush_i,
  input  logic [ce_pkg::OP_WIDTH-1:0]    op1_i,
  input  logic                           stage2_max_i,
  output logic                           sel_minmax_o,
  output logic                           cmp_en_o,
  output logic                           cmp_max_o,
  output logic                           out_valid_o,
  output logic                           busy_o
);

  logic [ce_pkg::PIPE_DEPTH-1:0]                        valid_q;
  logic [ce_pkg::PIPE_DEPTH-1:0][ce_pkg::OP_WIDTH-1:0]  op_q;
  logic [ce_pkg::PIPE_DEPTH-1:0]                        max_q;
  logic [ce_pkg::OP_WIDTH-1:0]                          op_last;

  // Valid bits, flush wins over enable and over a new item
  always_ff @(posedge stage2_noncomp_input_pipe_clk or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (flush_i) begin
      valid_q <= '0;
    end else if (reg_enable_i) begin
      valid_q[0] <= in_valid_i;
      for (int i = 1; i < ce_pkg::PIPE_DEPTH; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  // Per-item operation info follows the valid bit
  always_ff @(posedge stage2_noncomp_input_pipe_clk or negedge rst_ni) begin
    if (!rst_ni) begin
      op_q  <= '0;
      max_q <= '0;
    end else if (reg_enable_i) begin
      op_q[0]  <= op1_i;
      max_q[0] <= stage2_max_i;
      for (int i = 1; i < ce_pkg::PIPE_DEPTH; i++) begin
        op_q[i]  <= op_q[i-1];
        max_q[i] <= max_q[i-1];
      end
    end
  end

  assign op_last = op_q[ce_pkg::PIPE_DEPTH-1];

  // Anything other than the two multiply codes takes the min/max path
  assign sel_minmax_o = (op_last != ce_pkg::OP1_MUL) && (op_last != ce_pkg::OP1_MUL_CMP);
  assign cmp_en_o     = (op_last != ce_pkg::OP1_MUL);
  assign cmp_max_o    = max_q[ce_pkg::PIPE_DEPTH-1];

  assign out_valid_o = valid_q[ce_pkg::PIPE_DEPTH-1];
  assign busy_o      = |valid_q;

endmodule

// File: ce_top.sv
// ------------------------------------------------
// Two-stage FP16 computing element, top level
// Stage 1 multiplies X by W or takes their min/max,
// stage 2 optionally compares with the bias Y.
// Results come out PIPE_DEPTH enabled edges later.
// ------------------------------------------------

`timescale 1ns/1ps

module ce_top (
  input  logic                         stage2_noncomp_input_pipe_clk,
  input  logic                         rst_ni,
  input  logic [ce_pkg::FP_WIDTH-1:0]  x_i,
  input  logic [ce_pkg::FP_WIDTH-1:0]  w_i,
  input  logic [ce_pkg::FP_WIDTH-1:0]  y_i,
  input  logic [ce_pkg::OP_WIDTH-1:0]  op1_i,
  input  logic                         stage1_max_i,
  input  logic                         stage2_max_i,
  input  logic                         in_valid_i,
  input  logic                         reg_enable_i,
  input  logic                         flush_i,
  output logic [ce_pkg::FP_WIDTH-1:0]  z_o,
  output logic                         out_valid_o,
  output logic                         busy_o
);

  logic [ce_pkg::FP_WIDTH-1:0] mul_res;
  logic [ce_pkg::FP_WIDTH-1:0] minmax_res;
  logic                        sel_minmax;
  logic                        cmp_en;
  logic                        cmp_max;

  ce_ctrl i_ctrl (
    .stage2_noncomp_input_pipe_clk (stage2_noncomp_input_pipe_clk),
    .rst_ni                        (rst_ni),
    .in_valid_i                    (in_valid_i),
    .reg_enable_i                  (reg_enable_i),
    .flush_i                       (flush_i),
    .op1_i                         (op1_i),
    .stage2_max_i                  (stage2_max_i),
    .sel_minmax_o                  (sel_minmax),
    .cmp_en_o                      (cmp_en),
    .cmp_max_o                     (cmp_max),
    .out_valid_o                   (out_valid_o),
    .busy_o                        (busy_o)
  );

  // Stage 1, both units run on every item and the control picks one
  ce_fp_mul i_stage1_mul (
    .stage2_noncomp_input_pipe_clk (stage2_noncomp_input_pipe_clk),
    .rst_ni                        (rst_ni),
    .reg_enable_i                  (reg_enable_i),
    .a_i                           (x_i),
    .b_i                           (w_i),
    .prod_o                        (mul_res)
  );

  ce_fp_minmax #(
    .NUM_PIPE (ce_pkg::PIPE_DEPTH)
  ) i_stage1_minmax (
    .stage2_noncomp_input_pipe_clk (stage2_noncomp_input_pipe_clk),
    .rst_ni                        (rst_ni),
    .reg_enable_i                  (reg_enable_i),
    .a_i                           (x_i),
    .b_i                           (w_i),
    .max_i                         (stage1_max_i),
    .res_o                         (minmax_res)
  );

  ce_result_stage i_result_stage (
    .stage2_noncomp_input_pipe_clk (stage2_noncomp_input_pipe_clk),
    .rst_ni                        (rst_ni),
    .reg_enable_i                  (reg_enable_i),
    .y_i                           (y_i),
    .mul_res_i                     (mul_res),
    .minmax_res_i                  (minmax_res),
    .sel_minmax_i                  (sel_minmax),
    .cmp_en_i                      (cmp_en),
    .cmp_max_i                     (cmp_max),
    .z_o                           (z_o)
  );

endmodule

// File: tb_clk_gen.sv
// ------------------------------------------------
// Testbench clock and reset source
// Free-running clock and an active-low reset that
// is released after RESET_CYCLES rising edges.
// ------------------------------------------------

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int unsigned PERIOD_NS    = 100,
  parameter int unsigned RESET_CYCLES = 10
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

// File: ce_checker.sv
// ------------------------------------------------
// Protocol assertions for the computing element
// Bound into every ce_top instance by the bind at
// the end of this file.
// ------------------------------------------------

`timescale 1ns/1ps

module ce_checker (
  input logic stage2_noncomp_input_pipe_clk,
  input logic rst_ni,
  input logic flush_i,
  input logic out_valid_i,
  input logic busy_i
);

  int unsigned fail_count = 0;

  // Async reset holds the control pipeline empty
  assert property (@(posedge stage2_noncomp_input_pipe_clk)
    !rst_ni |-> (!out_valid_i && !busy_i))
  else begin
    $error("out_valid_o or busy_o high during reset");
    fail_count++;
  end

  assert property (@(posedge stage2_noncomp_input_pipe_clk) disable iff (!rst_ni)
    out_valid_i |-> busy_i)
  else begin
    $error("out_valid_o high while busy_o is low");
    fail_count++;
  end

  // A flush empties the pipeline on the same edge
  assert property (@(posedge stage2_noncomp_input_pipe_clk) disable iff (!rst_ni)
    flush_i |=> !out_valid_i)
  else begin
    $error("out_valid_o high in the cycle after a flush");
    fail_count++;
  end

endmodule

bind ce_top ce_checker i_checker (
  .stage2_noncomp_input_pipe_clk (stage2_noncomp_input_pipe_clk),
  .rst_ni                        (rst_ni),
  .flush_i                       (flush_i),
  .out_valid_i                   (out_valid_o),
  .busy_i                        (busy_o)
);

// File: tb_ce.sv
// ------------------------------------------------
// Testbench for the FP16 computing element
// Random stimulus with stalls and flushes, a model
// of the FP16 rules and an in-order scoreboard.
// Prints one line per test and a closing summary.
// ------------------------------------------------

`timescale 1ns/1ps

module tb_ce;

  localparam int unsigned CLK_PERIOD   = 100;
  localparam int unsigned RESET_CYCLES = 10;
  localparam int unsigned IDLE_CYCLES  = 8;
  localparam int unsigned TEST_CYCLES  = 300;
  localparam int unsigned N_TESTS      = 5;
  localparam int unsigned DRAIN_MAX    = 2 * ce_pkg::PIPE_DEPTH + 4;
  localparam int unsigned WATCHDOG_CYCLES =
    RESET_CYCLES + IDLE_CYCLES + N_TESTS * (TEST_CYCLES + DRAIN_MAX + 1) + 50;

  // Operation selection beyond the fixed codes
  localparam int OPS_ANY    = -1;
  localparam int OPS_MINMAX = -2;

  logic                          stage2_noncomp_input_pipe_clk;
  logic                          rst_n;
  logic [ce_pkg::FP_WIDTH-1:0]   x;
  logic [ce_pkg::FP_WIDTH-1:0]   w;
  logic [ce_pkg::FP_WIDTH-1:0]   y;
  logic [ce_pkg::OP_WIDTH-1:0]   op1;
  logic                          stage1_max;
  logic                          stage2_max;
  logic                          in_valid;
  logic                          reg_enable;
  logic                          flush;
  logic [ce_pkg::FP_WIDTH-1:0]   z;
  logic                          out_valid;
  logic                          busy;

  integer                        seed;
  logic [ce_pkg::FP_WIDTH-1:0]   exp_q[$];
  int unsigned                   tag_q[$];
  int unsigned                   edge_count = 0;
  int unsigned                   n_checks   = 0;
  int unsigned                   n_errors   = 0;
  logic                          new_out    = 1'b0;
  logic                          flushed    = 1'b0;
  logic [ce_pkg::FP_WIDTH-1:0]   held_z     = '0;

  tb_clk_gen #(
    .PERIOD_NS    (CLK_PERIOD),
    .RESET_CYCLES (RESET_CYCLES)
  ) i_clk_gen (
    .clk_o  (stage2_noncomp_input_pipe_clk),
    .rst_no (rst_n)
  );

  ce_top i_dut (
    .stage2_noncomp_input_pipe_clk (stage2_noncomp_input_pipe_clk),
    .rst_ni                        (rst_n),
    .x_i                           (x),
    .w_i                           (w),
    .y_i                           (y),
    .op1_i                         (op1),
    .stage1_max_i                  (stage1_max),
    .stage2_max_i                  (stage2_max),
    .in_valid_i                    (in_valid),
    .reg_enable_i                  (reg_enable),
    .flush_i                       (flush),
    .z_o                           (z),
    .out_valid_o                   (out_valid),
    .busy_o                        (busy)
  );

  function automatic logic is_nan(input logic [15:0] v);
    return (v[14:10] == 5'h1F) && (v[9:0] != 10'h0);
  endfunction

  function automatic logic is_inf(input logic [15:0] v);
    return (v[14:10] == 5'h1F) && (v[9:0] == 10'h0);
  endfunction

  // Signed integer that orders FP16 values, -0 just below +0
  function automatic int order_key(input logic [15:0] v);
    return v[15] ? -int'(v[14:0]) - 1 : int'(v[14:0]);
  endfunction

  function automatic logic [15:0] model_minmax(input logic [15:0] a, input logic [15:0] b,
                                               input logic want_max);
    if (is_nan(a) && is_nan(b)) return ce_pkg::FP_QNAN;
    if (is_nan(a)) return b;
    if (is_nan(b)) return a;
    if (want_max) return (order_key(a) >= order_key(b)) ? a : b;
    return (order_key(a) <= order_key(b)) ? a : b;
  endfunction

  // Truncating product, subnormals in and out become zero
  function automatic logic [15:0] model_mul(input logic [15:0] a, input logic [15:0] b);
    int          ea;
    int          eb;
    int          e;
    int unsigned p;
    logic        s;
    s  = a[15] ^ b[15];
    ea = a[14:10];
    eb = b[14:10];
    if (is_nan(a) || is_nan(b)) return ce_pkg::FP_QNAN;
    if ((is_inf(a) && eb == 0) || (is_inf(b) && ea == 0)) return ce_pkg::FP_QNAN;
    if (is_inf(a) || is_inf(b)) return {s, 5'h1F, 10'h0};
    if (ea == 0 || eb == 0) return {s, 15'h0};
    p = (1024 + a[9:0]) * (1024 + b[9:0]);
    e = ea + eb - int'(ce_pkg::EXP_BIAS);
    if (p >= (1 << 21)) begin
      p = p >> 1;
      e = e + 1;
    end
    if (e >= 31) return {s, 5'h1F, 10'h0};
    if (e <= 0) return {s, 15'h0};
    return {s, e[4:0], p[19:10]};
  endfunction

  function automatic logic [15:0] expect_z(input logic [1:0] op, input logic [15:0] xv,
                                           input logic [15:0] wv, input logic [15:0] yv,
                                           input logic s1max, input logic s2max);
    logic [15:0] s1;
    if (op == ce_pkg::OP1_MUL) return model_mul(xv, wv);
    s1 = (op == ce_pkg::OP1_MUL_CMP) ? model_mul(xv, wv) : model_minmax(xv, wv, s1max);
    return model_minmax(s1, yv, s2max);
  endfunction

  // Zeros, infinities, NaNs, subnormals and normals of two exponent spreads
  function automatic logic [15:0] make_operand(input logic [31:0] r);
    logic [4:0] e;
    e = r[30:26];
    if (e == 5'h00) e = 5'h01;
    if (e == 5'h1F) e = 5'h1E;
    if (r[3]) e = 5'd8 + {1'b0, r[30:27]};
    case (r[2:0])
      3'd0:    return {r[31], 15'h0};
      3'd1:    return {r[31], 5'h1F, 10'h0};
      3'd2:    return {r[31], 5'h1F, r[25:16] | 10'h1};
      3'd3:    return {r[31], 5'h00, r[25:16]};
      default: return {r[31], e, r[25:16]};
    endcase
  endfunction

  function automatic int unsigned total_errors();
    return n_errors + i_dut.i_checker.fail_count;
  endfunction

  // Reference model, sees the same pre-edge inputs as the DUT
  always @(posedge stage2_noncomp_input_pipe_clk) begin
    if (rst_n) begin
      new_out = reg_enable && !flush;
      flushed = flush;
      if (flush) begin
        exp_q.delete();
        tag_q.delete();
      end else if (reg_enable && in_valid) begin
        exp_q.push_back(expect_z(op1, x, w, y, stage1_max, stage2_max));
        tag_q.push_back(edge_count);
      end
      if (reg_enable) edge_count++;
    end
  end

  // Scoreboard, samples mid-cycle
  always @(negedge stage2_noncomp_input_pipe_clk) begin
    logic [ce_pkg::FP_WIDTH-1:0] exp_z;
    int unsigned                 tag;
    if (rst_n) begin
      if (flushed) begin
        assert (!out_valid)
        else begin
          $display("Fail at %0t: out_valid_o = %b, expected 0 after flush", $time, out_valid);
          n_errors++;
        end
      end
      if (out_valid && new_out) begin
        if (exp_q.size() == 0) begin
          $display("Error at %0t: a result came out with no item in flight", $time);
          n_errors++;
        end else begin
          exp_z = exp_q.pop_front();
          tag   = tag_q.pop_front();
          n_checks++;
          assert (z === exp_z)
          else begin
            $display("Fail at %0t: z_o = %h, expected %h", $time, z, exp_z);
            n_errors++;
          end
          assert (edge_count - tag == ce_pkg::PIPE_DEPTH)
          else begin
            $display("Fail at %0t: out_valid_o latency = %0d, expected %0d",
                     $time, edge_count - tag, ce_pkg::PIPE_DEPTH);
            n_errors++;
          end
        end
        held_z = z;
      end else if (out_valid) begin
        // Stalled, the output must not move
        n_checks++;
        assert (z === held_z)
        else begin
          $display("Fail at %0t: z_o = %h, expected held %h", $time, z, held_z);
          n_errors++;
        end
      end
    end
  end

  task automatic report_test(input string name, input int unsigned c0, input int unsigned e0);
    $display("Test %s done: %0d checks, %0d errors", name, n_checks - c0, total_errors() - e0);
  endtask

  task automatic run_test(input string name, input int op_sel, input int unsigned idle_pct,
                          input int unsigned stall_pct, input int unsigned flush_pct);
    logic [31:0] r;
    int unsigned c0;
    int unsigned e0;
    int unsigned waited;
    c0 = n_checks;
    e0 = total_errors();
    for (int unsigned cyc = 0; cyc < TEST_CYCLES; cyc++) begin
      @(posedge stage2_noncomp_input_pipe_clk);
      r = $random(seed);
      x <= make_operand($random(seed));
      w <= make_operand($random(seed));
      y <= make_operand($random(seed));
      if (op_sel >= 0) op1 <= op_sel[1:0];
      else if (op_sel == OPS_MINMAX) op1 <= {1'b1, r[0]};
      else op1 <= r[1:0];
      stage1_max <= r[2];
      stage2_max <= r[3];
      in_valid   <= (r[15:8] % 8'd100) >= idle_pct;
      reg_enable <= (r[23:16] % 8'd100) >= stall_pct;
      flush      <= (r[31:24] % 8'd100) < flush_pct;
    end
    @(posedge stage2_noncomp_input_pipe_clk);
    in_valid   <= 1'b0;
    reg_enable <= 1'b1;
    flush      <= 1'b0;
    waited = 0;
    do begin
      @(negedge stage2_noncomp_input_pipe_clk);
      waited++;
    end while (busy && waited < DRAIN_MAX);
    if (busy || exp_q.size() != 0) begin
      $display("Error at %0t: pipeline did not drain, %0d results never came out",
               $time, exp_q.size());
      n_errors++;
      exp_q.delete();
      tag_q.delete();
    end
    report_test(name, c0, e0);
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Error: simulation ran past its time limit");
    $display("Checks failed");
    $finish;
  end

  initial begin
    int unsigned c0;
    int unsigned e0;
    seed       = 32'hc44bc83b;
    x          = '0;
    w          = '0;
    y          = '0;
    op1        = '0;
    stage1_max = 1'b0;
    stage2_max = 1'b0;
    in_valid   = 1'b0;
    reg_enable = 1'b0;
    flush      = 1'b0;

    c0 = n_checks;
    e0 = total_errors();
    @(posedge rst_n);
    @(negedge stage2_noncomp_input_pipe_clk);
    n_checks++;
    assert (!out_valid && !busy)
    else begin
      $display("Fail at %0t: out_valid_o = %b busy_o = %b, expected 0 and 0",
               $time, out_valid, busy);
      n_errors++;
    end
    repeat (IDLE_CYCLES) begin
      @(posedge stage2_noncomp_input_pipe_clk);
      reg_enable <= 1'b1;
    end
    report_test("reset", c0, e0);

    run_test("mul", ce_pkg::OP1_MUL, 0, 0, 0);
    run_test("mul_cmp", ce_pkg::OP1_MUL_CMP, 0, 0, 0);
    run_test("minmax", OPS_MINMAX, 0, 0, 0);
    run_test("stall", OPS_ANY, 20, 35, 0);
    run_test("flush", OPS_ANY, 10, 15, 6);

    $display("Summary: %0d checks, %0d errors", n_checks, total_errors());
    if (total_errors() == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: flist.f
ce_pkg.sv
ce_fp_mul.sv
ce_fp_minmax.sv
ce_result_stage.sv
ce_ctrl.sv
ce_top.sv
tb_clk_gen.sv
ce_checker.sv
tb_ce.sv

// File: Bender.yml
package:
  name: ce_fp16

sources:
  - ce_pkg.sv
  - ce_fp_mul.sv
  - ce_fp_minmax.sv
  - ce_result_stage.sv
  - ce_ctrl.sv
  - ce_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - ce_checker.sv
      - tb_ce.sv
